// File: hdl/mlp_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mlp_params.svh"

module mlp_cmd_parser
    import uart_mlp_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  byte_t              rx_byte,
    payload_if.writer          pl,
    output logic               start_weights,
    output logic               start_acts,
    output logic               start_mlp,
    input  logic [3:0]         mlp_state,
    input  logic [4:0]         mlp_cycle_cnt,
    input  logic signed [31:0] mlp_acc0,
    output logic               tx_push,
    output byte_t              tx_data,
    input  logic               tx_credit
);

    localparam int IDX_W    = $clog2(`PAYLOAD_BYTES);
    localparam int RESP_W   = $clog2(`RESULT_BYTES);
    localparam int CREDIT_W = $clog2(`TX_QUEUE_DEPTH) + 1;

    typedef enum logic [1:0] {P_CMD, P_PAYLOAD, P_RESP} parser_state_e;

    parser_state_e             state;
    mlp_cmd_e                  cmd;
    logic [IDX_W-1:0]          pl_idx;
    byte_t [`RESULT_BYTES-1:0] resp;
    logic [RESP_W-1:0]         resp_idx;
    logic [RESP_W-1:0]         resp_last;
    logic [CREDIT_W-1:0]       credits;
    status_byte_u              status;

    always_comb begin
        status.fields.state = mlp_state;
        status.fields.cycle = mlp_cycle_cnt[3:0];
    end

    // Payload bytes go to the register block in the cycle they arrive
    assign pl.wr_en   = (state == P_PAYLOAD) && rx_valid;
    assign pl.wr_idx  = pl_idx;
    assign pl.wr_data = rx_byte;

    // Execute drops weights-ready together with the start pulse
    assign pl.clr_ready = (state == P_CMD) && rx_valid && (rx_byte == CMD_EXECUTE);

    assign tx_push = (state == P_RESP) && (credits != '0);
    assign tx_data = resp[resp_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(`TX_QUEUE_DEPTH);
        end else begin
            credits <= credits + {{(CREDIT_W-1){1'b0}}, tx_credit}
                               - {{(CREDIT_W-1){1'b0}}, tx_push};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= P_CMD;
            cmd           <= CMD_WRITE_WEIGHT;
            pl_idx        <= '0;
            resp_idx      <= '0;
            start_weights <= 1'b0;
            start_acts    <= 1'b0;
            start_mlp     <= 1'b0;
        end else begin
            start_weights <= 1'b0;
            start_acts    <= 1'b0;
            start_mlp     <= 1'b0;
            case (state)
                P_CMD: begin
                    if (rx_valid) begin
                        pl_idx   <= '0;
                        resp_idx <= '0;
                        case (rx_byte)
                            CMD_WRITE_WEIGHT, CMD_WRITE_ACT: begin
                                cmd   <= mlp_cmd_e'(rx_byte);
                                state <= P_PAYLOAD;
                            end
                            CMD_EXECUTE: start_mlp <= 1'b1;
                            CMD_READ_RESULT: begin
                                // Byte 0 of the packed array is the low byte
                                resp      <= mlp_acc0;
                                resp_last <= RESP_W'(`RESULT_BYTES - 1);
                                state     <= P_RESP;
                            end
                            CMD_STATUS: begin
                                resp[0]   <= status.raw;
                                resp_last <= '0;
                                state     <= P_RESP;
                            end
                            // Unknown codes are ignored
                            default: state <= P_CMD;
                        endcase
                    end
                end
                P_PAYLOAD: begin
                    if (rx_valid) begin
                        if (pl_idx == IDX_W'(`PAYLOAD_BYTES - 1)) begin
                            start_weights <= (cmd == CMD_WRITE_WEIGHT);
                            start_acts    <= (cmd == CMD_WRITE_ACT);
                            state         <= P_CMD;
                        end else begin
                            pl_idx <= pl_idx + 1'b1;
                        end
                    end
                end
                P_RESP: begin
                    // Waits here without credits, receive bytes are lost meanwhile
                    if (tx_push) begin
                        if (resp_idx == resp_last) begin
                            state <= P_CMD;
                        end else begin
                            resp_idx <= resp_idx + 1'b1;
                        end
                    end
                end
                default: state <= P_CMD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/mlp_load_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_load_sequencer
    import uart_mlp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_weights,
    input  logic      start_acts,
    payload_if.reader pl,
    output logic      wf_reset,
    output logic      wf_push_col0,
    output logic      wf_push_col1,
    output byte_t     wf_data,
    output logic      init_act_valid,
    output act_row_t  init_act_data
);

    // Weight step 0 is idle, 1 resets the FIFO and 2 to 5 push one byte each
    logic [2:0] w_step;
    logic [1:0] w_byte;

    // Activation step 0 is idle, 1 sends row 0 and 2 sends row 1
    logic [1:0] a_step;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_step <= '0;
            a_step <= '0;
        end else begin
            if (start_weights) begin
                w_step <= 3'd1;
            end else if (w_step == 3'd5) begin
                w_step <= '0;
            end else if (w_step != '0) begin
                w_step <= w_step + 1'b1;
            end

            if (start_acts) begin
                a_step <= 2'd1;
            end else if (a_step == 2'd2) begin
                a_step <= '0;
            end else if (a_step != '0) begin
                a_step <= a_step + 1'b1;
            end
        end
    end

    assign w_byte = w_step[1:0] - 2'd2;

    // Pushes alternate col0, col1, col0, col1
    assign wf_reset     = (w_step == 3'd1);
    assign wf_push_col0 = (w_step == 3'd2) || (w_step == 3'd4);
    assign wf_push_col1 = (w_step == 3'd3) || (w_step == 3'd5);
    assign wf_data      = pl.payload[w_byte];
    assign pl.set_ready = (w_step == 3'd5);

    assign init_act_valid = (a_step != '0);
    assign init_act_data  = (a_step == 2'd1) ? {pl.payload[1], pl.payload[0]}
                                             : {pl.payload[3], pl.payload[2]};

endmodule

`default_nettype wire

// File: hdl/mlp_payload_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mlp_payload_regs (
    input  logic     clk,
    input  logic     rst,
    payload_if.store pl
);

    // Payload bytes as written by the parser
    always_ff @(posedge clk) begin
        if (pl.wr_en) begin
            pl.payload[pl.wr_idx] <= pl.wr_data;
        end
    end

    // Clear wins when both arrive together
    always_ff @(posedge clk) begin
        if (rst) begin
            pl.weights_ready <= 1'b0;
        end else if (pl.clr_ready) begin
            pl.weights_ready <= 1'b0;
        end else if (pl.set_ready) begin
            pl.weights_ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/payload_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mlp_params.svh"

interface payload_if
    import uart_mlp_pkg::*;
();

    // Byte writes from the parser
    logic                               wr_en;
    logic [$clog2(`PAYLOAD_BYTES)-1:0]  wr_idx;
    byte_t                              wr_data;

    // Stored payload and the weights-ready flag
    byte_t [`PAYLOAD_BYTES-1:0]         payload;
    logic                               weights_ready;
    logic                               set_ready;
    logic                               clr_ready;

    modport writer (output wr_en, wr_idx, wr_data, clr_ready);
    modport store  (input wr_en, wr_idx, wr_data, set_ready, clr_ready,
                    output payload, weights_ready);
    modport reader (input payload, output set_ready);

endinterface

`default_nettype wire

// File: hdl/uart_mlp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_mlp_ctrl
    import uart_mlp_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               uart_rx_line,
    output logic               uart_tx_line,
    output logic               wf_reset,
    output logic               wf_push_col0,
    output logic               wf_push_col1,
    output byte_t              wf_data,
    output logic               init_act_valid,
    output act_row_t           init_act_data,
    output logic               start_mlp,
    output logic               weights_ready,
    input  logic [3:0]         mlp_state,
    input  logic [4:0]         mlp_cycle_cnt,
    input  logic signed [31:0] mlp_acc0
);

    logic  rx_valid;
    byte_t rx_byte;
    logic  tx_push;
    byte_t tx_data;
    logic  tx_credit;
    logic  start_weights;
    logic  start_acts;

    payload_if pl ();

    assign weights_ready = pl.weights_ready;

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx_line),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    mlp_cmd_parser u_parser (
        .clk           (clk),
        .rst           (rst),
        .rx_valid      (rx_valid),
        .rx_byte       (rx_byte),
        .pl            (pl.writer),
        .start_weights (start_weights),
        .start_acts    (start_acts),
        .start_mlp     (start_mlp),
        .mlp_state     (mlp_state),
        .mlp_cycle_cnt (mlp_cycle_cnt),
        .mlp_acc0      (mlp_acc0),
        .tx_push       (tx_push),
        .tx_data       (tx_data),
        .tx_credit     (tx_credit)
    );

    mlp_payload_regs u_regs (
        .clk (clk),
        .rst (rst),
        .pl  (pl.store)
    );

    mlp_load_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .start_weights  (start_weights),
        .start_acts     (start_acts),
        .pl             (pl.reader),
        .wf_reset       (wf_reset),
        .wf_push_col0   (wf_push_col0),
        .wf_push_col1   (wf_push_col1),
        .wf_data        (wf_data),
        .init_act_valid (init_act_valid),
        .init_act_data  (init_act_data)
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_push   (tx_push),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .tx        (uart_tx_line)
    );

endmodule

`default_nettype wire

// File: hdl/uart_mlp_params.svh
`ifndef UART_MLP_PARAMS_SVH
`define UART_MLP_PARAMS_SVH

// System clock and serial line rate
`define CLOCK_FREQ 25_000_000
`define BAUD_RATE 3_125_000

// Clocks per serial bit, 8 at these rates
`define CLKS_PER_BIT (`CLOCK_FREQ / `BAUD_RATE)

// Data bytes following a write command
`define PAYLOAD_BYTES 4

// Transmit queue slots, also the parser's starting credits
`define TX_QUEUE_DEPTH 4

// Accumulator bytes returned by read-result
`define RESULT_BYTES 4

`endif

// File: hdl/uart_mlp_pkg.sv
`default_nettype none

package uart_mlp_pkg;

    // One serial data byte
    typedef logic [7:0] byte_t;

    // One activation row, lower-indexed byte in the low half
    typedef logic [15:0] act_row_t;

    // Command codes seen on the serial line
    typedef enum logic [7:0] {
        CMD_WRITE_WEIGHT = 8'h01,
        CMD_WRITE_ACT    = 8'h02,
        CMD_EXECUTE      = 8'h03,
        CMD_READ_RESULT  = 8'h04,
        CMD_STATUS       = 8'h05
    } mlp_cmd_e;

    // Status response fields, state on top
    typedef struct packed {
        logic [3:0] state;
        logic [3:0] cycle;
    } status_fields_t;

    // Status byte, seen either as a raw byte or as its two nibbles
    typedef union packed {
        byte_t          raw;
        status_fields_t fields;
    } status_byte_u;

endpackage

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mlp_params.svh"

module uart_rx
    import uart_mlp_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output logic  rx_valid,
    output byte_t rx_byte
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;

    assign rx_byte = shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync  <= 2'b11;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // Two flops against metastability on the line
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at its middle, then step a full bit each time
                    if (baud_cnt == HALF_BIT) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == FULL_BIT) begin
                        baud_cnt <= '0;
                        shift    <= {rx_sync[1], shift[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == FULL_BIT) begin
                        // Frames with a low stop bit are dropped
                        rx_valid <= rx_sync[1];
                        state    <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mlp_params.svh"

module uart_tx
    import uart_mlp_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_push,
    input  byte_t tx_data,
    output logic  tx_credit,
    output logic  tx
);

    localparam int PTR_W = $clog2(`TX_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

    byte_t            queue [`TX_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             busy;
    logic [9:0]       frame;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;
    logic             frame_done;
    logic             pop;
    byte_t            pop_data;

    // Last cycle of the stop bit lets the next frame follow without a gap
    assign frame_done = busy && (baud_cnt == FULL_BIT) && (bit_idx == 4'd9);

    // An empty queue passes a pushed byte straight to the shifter
    assign pop      = (!busy || frame_done) && ((count != '0) || tx_push);
    assign pop_data = (count != '0) ? queue[rd_ptr] : tx_data;

    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (tx_push) begin
            queue[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tx_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, tx_push} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            frame     <= '1;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            tx_credit <= 1'b0;
        end else begin
            // One credit back for each byte taken into the shifter
            tx_credit <= pop;
            if (pop) begin
                busy     <= 1'b1;
                frame    <= {1'b1, pop_data, 1'b0};
                baud_cnt <= '0;
                bit_idx  <= '0;
            end else if (busy) begin
                if (baud_cnt == FULL_BIT) begin
                    baud_cnt <= '0;
                    frame    <= {1'b1, frame[9:1]};
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 4'd9) begin
                        busy <= 1'b0;
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/uart_mlp_pkg.sv
hdl/payload_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/mlp_cmd_parser.sv
hdl/mlp_payload_regs.sv
hdl/mlp_load_sequencer.sv
hdl/uart_mlp_ctrl.sv
verif/tb_uart_mlp_ctrl.sv

// File: verif/tb_uart_mlp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mlp_params.svh"

module tb_uart_mlp_ctrl
    import uart_mlp_pkg::*;
();

    localparam int N_TESTS        = 30;
    localparam int FRAME_CYCLES   = 10 * `CLKS_PER_BIT;
    localparam int WAIT_LIMIT     = 12 * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = N_TESTS * 60 * FRAME_CYCLES;

    // Result kinds collected by the monitors
    localparam int K_WEIGHT = 0;
    localparam int K_ACT    = 1;
    localparam int K_START  = 2;
    localparam int K_TX     = 3;

    logic               clk;
    logic               rst;
    logic               uart_rx_line;
    logic               uart_tx_line;
    logic               wf_reset;
    logic               wf_push_col0;
    logic               wf_push_col1;
    byte_t              wf_data;
    logic               init_act_valid;
    act_row_t           init_act_data;
    logic               start_mlp;
    logic               weights_ready;
    logic [3:0]         mlp_state;
    logic [4:0]         mlp_cycle_cnt;
    logic signed [31:0] mlp_acc0;

    integer   seed = 32'hd975_ea9c;
    int       model_ready = 0;
    int       start_cnt = 0;
    // Weight event codes 0 FIFO reset, 1 push col0 and 2 push col1
    int       wev_q[$];
    byte_t    wdata_q[$];
    act_row_t act_q[$];
    byte_t    tx_q[$];

    uart_mlp_ctrl dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            report_error($sformatf("Mismatch %s: expected 0x%h, actual 0x%h",
                                   name, expected, actual));
        end
    endtask

    task automatic compare_row(input string name, input act_row_t expected,
                               input act_row_t actual);
        if (actual !== expected) begin
            report_error($sformatf("Mismatch %s: expected 0x%h, actual 0x%h",
                                   name, expected, actual));
        end
    endtask

    task automatic compare_status(input string name, input status_byte_u expected,
                                  input status_byte_u actual);
        if (actual.raw !== expected.raw) begin
            report_error($sformatf("Mismatch %s: expected 0x%h, actual 0x%h",
                                   name, expected.raw, actual.raw));
        end
    endtask

    task automatic compare_pulse(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_error($sformatf("Mismatch %s: expected %0d, actual %0d",
                                   name, expected, actual));
        end
    endtask

    // MLP side pulses sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wf_push_col0 && wf_push_col1) begin
                report_error("Both weight FIFO columns were pushed in the same cycle");
            end
            if (wf_reset) begin
                wev_q.push_back(0);
            end
            if (wf_push_col0 || wf_push_col1) begin
                wev_q.push_back(wf_push_col0 ? 1 : 2);
                wdata_q.push_back(wf_data);
            end
            if (init_act_valid) begin
                act_q.push_back(init_act_data);
            end
            if (start_mlp) begin
                start_cnt++;
            end
        end
    end

    // Serial decoder for the response line
    initial begin : tx_decoder
        byte_t b;
        forever begin
            @(negedge clk);
            if (uart_tx_line === 1'b0) begin
                repeat (`CLKS_PER_BIT / 2 - 1) @(negedge clk);
                if (uart_tx_line !== 1'b0) begin
                    report_error("Start bit on the transmit line did not hold low");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (`CLKS_PER_BIT) @(negedge clk);
                    b[i] = uart_tx_line;
                end
                repeat (`CLKS_PER_BIT) @(negedge clk);
                if (uart_tx_line !== 1'b1) begin
                    report_error("Stop bit on the transmit line read low");
                end
                tx_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        report_error("Watchdog expired, the testbench stopped making progress");
    end

    function automatic int result_count(input int kind);
        case (kind)
            K_WEIGHT: return wev_q.size();
            K_ACT:    return act_q.size();
            K_START:  return start_cnt;
            default:  return tx_q.size();
        endcase
    endfunction

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx_line <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic wait_results(input string name, input int kind, input int n);
        int waited;
        waited = 0;
        while (result_count(kind) < n) begin
            if (waited == WAIT_LIMIT) begin
                report_error($sformatf("%s: no result after %0d cycles", name, waited));
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic clear_results();
        @(posedge clk);
        wev_q.delete();
        wdata_q.delete();
        act_q.delete();
        tx_q.delete();
        start_cnt = 0;
    endtask

    // Let the line go quiet, then count everything seen in this test
    task automatic check_quiet(input string name, input int nw, input int na,
                               input int ns, input int nt);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        compare_pulse({name, " weight events"}, nw, wev_q.size());
        compare_pulse({name, " activation rows"}, na, act_q.size());
        compare_pulse({name, " start pulses"}, ns, start_cnt);
        compare_pulse({name, " serial bytes"}, nt, tx_q.size());
        compare_pulse({name, " weights_ready"}, model_ready, weights_ready);
    endtask

    task automatic do_write_weight(input string name);
        byte_t p [`PAYLOAD_BYTES];
        for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
            p[i] = byte_t'($random(seed));
        end
        send_byte(CMD_WRITE_WEIGHT);
        for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
            send_byte(p[i]);
        end
        wait_results(name, K_WEIGHT, `PAYLOAD_BYTES + 1);
        compare_pulse({name, " FIFO reset first"}, 0, wev_q[0]);
        for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
            compare_pulse($sformatf("%s push %0d column", name, i), (i % 2) + 1, wev_q[i + 1]);
            compare_byte($sformatf("%s push %0d data", name, i), p[i], wdata_q[i]);
        end
        // Flag rises in the cycle after the last push
        @(negedge clk);
        compare_pulse({name, " weights_ready after pushes"}, 1, weights_ready);
        model_ready = 1;
        check_quiet(name, `PAYLOAD_BYTES + 1, 0, 0, 0);
    endtask

    task automatic do_write_act(input string name);
        byte_t p [`PAYLOAD_BYTES];
        for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
            p[i] = byte_t'($random(seed));
        end
        send_byte(CMD_WRITE_ACT);
        for (int i = 0; i < `PAYLOAD_BYTES; i++) begin
            send_byte(p[i]);
        end
        wait_results(name, K_ACT, 2);
        compare_row({name, " row 0"}, {p[1], p[0]}, act_q[0]);
        compare_row({name, " row 1"}, {p[3], p[2]}, act_q[1]);
        check_quiet(name, 0, 2, 0, 0);
    endtask

    task automatic do_execute(input string name);
        send_byte(CMD_EXECUTE);
        wait_results(name, K_START, 1);
        compare_pulse({name, " weights_ready with start"}, 0, weights_ready);
        model_ready = 0;
        check_quiet(name, 0, 0, 1, 0);
    endtask

    task automatic do_read_result(input string name);
        logic [31:0] acc;
        acc = $random(seed);
        @(posedge clk);
        mlp_acc0 <= acc;
        send_byte(CMD_READ_RESULT);
        wait_results(name, K_TX, `RESULT_BYTES);
        // Least significant byte goes out first
        for (int i = 0; i < `RESULT_BYTES; i++) begin
            compare_byte($sformatf("%s byte %0d", name, i), acc[8*i +: 8], tx_q[i]);
        end
        check_quiet(name, 0, 0, 0, `RESULT_BYTES);
    endtask

    task automatic do_status(input string name);
        logic [3:0]   st;
        logic [4:0]   cnt;
        status_byte_u expected;
        status_byte_u actual;
        st  = 4'($random(seed));
        cnt = 5'($random(seed));
        @(posedge clk);
        mlp_state     <= st;
        mlp_cycle_cnt <= cnt;
        // State in the upper nibble, low cycle bits below
        expected.raw = {st, cnt[3:0]};
        send_byte(CMD_STATUS);
        wait_results(name, K_TX, 1);
        actual.raw = tx_q[0];
        compare_status(name, expected, actual);
        check_quiet(name, 0, 0, 0, 1);
    endtask

    task automatic do_unknown(input string name);
        byte_t b;
        b = byte_t'($random(seed));
        while (b >= 8'h01 && b <= 8'h05) begin
            b = byte_t'($random(seed));
        end
        send_byte(b);
        check_quiet($sformatf("%s code 0x%h", name, b), 0, 0, 0, 0);
        // A valid command right after must still work
        do_status({name, " then status"});
    endtask

    initial begin : main
        int op;
        rst           = 1'b1;
        uart_rx_line  = 1'b1;
        mlp_state     = '0;
        mlp_cycle_cnt = '0;
        mlp_acc0      = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        clear_results();
        check_quiet("after reset", 0, 0, 0, 0);
        compare_pulse("after reset uart_tx_line", 1, uart_tx_line);

        // Each command once in order, then a random mix
        for (int t = 0; t < N_TESTS; t++) begin
            op = (t < 6) ? t : {$random(seed)} % 6;
            clear_results();
            case (op)
                0: do_write_weight($sformatf("test %0d write-weight", t));
                1: do_write_act($sformatf("test %0d write-activation", t));
                2: do_execute($sformatf("test %0d execute", t));
                3: do_read_result($sformatf("test %0d read-result", t));
                4: do_status($sformatf("test %0d status", t));
                default: do_unknown($sformatf("test %0d unknown", t));
            endcase
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
